// ==== line_car_tests.txt ====
# op name sensors(left,mid,right) enable_stop echo_width expected_left expected_right
# PRESS also pulses the start button; echo_width 0 means no echo.
LINE idle_center 010 0 0 OFF OFF
LINE idle_sharp_left 100 0 0 OFF OFF
PRESS start 010 0 0 FWD FWD
LINE straight_all 111 0 0 FWD FWD
LINE sharp_left 100 0 0 REV FWD
LINE lost_after_sharp_left 000 0 0 REV FWD
LINE split_after_sharp_left 101 0 0 REV FWD
LINE soft_left 110 0 0 OFF FWD
LINE sharp_right 001 0 0 FWD REV
LINE soft_right 011 0 0 FWD OFF
LINE lost_after_soft_right 000 0 0 FWD OFF
LINE split_after_soft_right 101 0 0 FWD OFF
LINE center 010 0 0 FWD FWD
PRESS stop 010 0 0 OFF OFF
LINE stopped_sharp_right 001 0 0 OFF OFF
PRESS restart 010 0 0 FWD FWD
LINE near_stop_disabled 010 0 4 FWD FWD
LINE near_stop 010 1 4 OFF OFF
LINE near_stop_turn 100 1 4 OFF OFF
LINE far_echo 100 1 20 REV FWD
LINE threshold_echo 011 1 10 FWD OFF
LINE below_threshold 011 1 9 OFF OFF
LINE no_echo 001 1 0 FWD REV
LINE short_stop_disabled 110 0 6 OFF FWD
LINE short_echo_center 010 1 2 OFF OFF
LINE clear_to_center 010 0 2 FWD FWD

// ==== line_car.f ====
line_car_pkg.sv
button_conditioner.sv
line_tracker.sv
sonic_ranger.sv
steer_ctrl.sv
motor_pwm.sv
line_car_top.sv
tb_line_car.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_line_car
FILELIST  ?= line_car.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_line_car.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_line_car;

    localparam int DEBOUNCE_LEN = 4;
    localparam int TRIG_CYCLES  = 3;
    localparam int PING_CYCLES  = 60;
    localparam int STOP_CYCLES  = 10;
    localparam int PWM_PERIOD   = 8;
    localparam int PWM_DUTY     = 3;
    localparam int CLK_PERIOD   = 20;
    localparam int PRESS_CYCLES = 6;
    localparam string TEST_FILE = "line_car_tests.txt";

    logic                              clk;
    logic                              rst_n;
    logic                              button;
    logic                              echo;
    logic [line_car_pkg::SENSOR_W-1:0] sensors;
    logic                              enable_stop;
    logic                              trig;
    logic                              left_pwm;
    logic                              right_pwm;
    line_car_pkg::motor_dir_e          left_dir;
    line_car_pkg::motor_dir_e          right_dir;
    logic [line_car_pkg::SENSOR_W-1:0] lights;

    int echo_width;  // Echo high time the responder plays back, 0 for none.
    int error_count;
    int num_tests;
    bit tests_loaded;

    // One entry per test line.
    string                             op_q[$];
    string                             name_q[$];
    logic [line_car_pkg::SENSOR_W-1:0] sensor_q[$];
    logic                              stop_q[$];
    int                                width_q[$];
    line_car_pkg::motor_dir_e          left_q[$];
    line_car_pkg::motor_dir_e          right_q[$];

    line_car_top #(
        .DEBOUNCE_LEN(DEBOUNCE_LEN),
        .TRIG_CYCLES (TRIG_CYCLES),
        .PING_CYCLES (PING_CYCLES),
        .STOP_CYCLES (STOP_CYCLES),
        .PWM_PERIOD  (PWM_PERIOD),
        .PWM_DUTY    (PWM_DUTY)
    ) i_line_car_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .button     (button),
        .echo       (echo),
        .sensors    (sensors),
        .enable_stop(enable_stop),
        .trig       (trig),
        .left_pwm   (left_pwm),
        .right_pwm  (right_pwm),
        .left_dir   (left_dir),
        .right_dir  (right_dir),
        .lights     (lights)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "Run aborted.");
    endtask

    task automatic check_dir(input string name, input line_car_pkg::motor_dir_e expected,
                             input line_car_pkg::motor_dir_e actual);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s: expected %s actual %s (%b)", name, expected.name(),
                     actual.name(), actual);
            $display("RESULT: FAIL");
            $fatal(1, "Direction mismatch.");
        end
    endtask

    task automatic check_lights(input string name,
                                input logic [line_car_pkg::SENSOR_W-1:0] expected,
                                input logic [line_car_pkg::SENSOR_W-1:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s lights: expected %b actual %b", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "Lights mismatch.");
        end
    endtask

    task automatic check_pwm(input string name, input int expected, input int actual);
        if (actual != expected) begin
            error_count++;
            $display("[ERROR] %s: expected %0d high cycles actual %0d", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "PWM mismatch.");
        end
    endtask

    task automatic check_trig(input string name, input int expected, input int actual);
        if (actual != expected) begin
            error_count++;
            $display("[ERROR] %s: expected %0d cycles actual %0d", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "Trigger timing mismatch.");
        end
    endtask

    function automatic line_car_pkg::motor_dir_e dir_from_text(input string text,
                                                               output bit ok);
        ok = 1'b1;
        if (text == "FWD") return line_car_pkg::MOTOR_FWD;
        if (text == "REV") return line_car_pkg::MOTOR_REV;
        if (text != "OFF") ok = 1'b0;
        return line_car_pkg::MOTOR_OFF;
    endfunction

    task automatic read_tests();
        int                                fd;
        int                                fields;
        int                                stop;
        int                                width;
        bit                                left_ok;
        bit                                right_ok;
        string                             line;
        string                             op;
        string                             name;
        string                             left_txt;
        string                             right_txt;
        logic [line_car_pkg::SENSOR_W-1:0] pattern;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) abort_run("Cannot open the test file line_car_tests.txt.");
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 2 || line[0] == "#") continue; // Blank or comment line.
            fields = $sscanf(line, "%s %s %b %d %d %s %s", op, name, pattern, stop, width,
                             left_txt, right_txt);
            if (fields != 7) abort_run({"Malformed line in the test file: ", line});
            if (op != "PRESS" && op != "LINE") abort_run({"Unknown operation: ", op});
            op_q.push_back(op);
            name_q.push_back(name);
            sensor_q.push_back(pattern);
            stop_q.push_back(stop != 0);
            width_q.push_back(width);
            left_q.push_back(dir_from_text(left_txt, left_ok));
            right_q.push_back(dir_from_text(right_txt, right_ok));
            if (!left_ok || !right_ok) abort_run({"Unknown direction in test ", name});
        end
        $fclose(fd);
    endtask

    task automatic press_button();
        button = 1'b1;
        repeat (PRESS_CYCLES) @(negedge clk);
        button = 1'b0;
    endtask

    // Counts high cycles of both enables over one PWM period.
    task automatic count_pwm(output int left_high, output int right_high);
        left_high  = 0;
        right_high = 0;
        repeat (PWM_PERIOD) begin
            @(negedge clk);
            if (left_pwm) left_high++;
            if (right_pwm) right_high++;
        end
    endtask

    task automatic run_test(input int idx);
        string name;
        int    exp_left_high;
        int    exp_right_high;
        int    left_high;
        int    right_high;
        name        = name_q[idx];
        sensors     = sensor_q[idx];
        enable_stop = stop_q[idx];
        echo_width  = width_q[idx];
        if (op_q[idx] == "PRESS") press_button();
        repeat (2 * PING_CYCLES) @(negedge clk); // Two pings settle the ranger.
        check_dir({name, " left_dir"}, left_q[idx], left_dir);
        check_dir({name, " right_dir"}, right_q[idx], right_dir);
        check_lights(name, sensor_q[idx], lights);
        exp_left_high  = (left_q[idx] == line_car_pkg::MOTOR_OFF) ? 0 : PWM_DUTY;
        exp_right_high = (right_q[idx] == line_car_pkg::MOTOR_OFF) ? 0 : PWM_DUTY;
        count_pwm(left_high, right_high);
        check_pwm({name, " left_pwm"}, exp_left_high, left_high);
        check_pwm({name, " right_pwm"}, exp_right_high, right_high);
    endtask

    // Echo returns two cycles after the trigger ends.
    initial begin
        echo = 1'b0;
        forever begin
            @(negedge trig);
            repeat (2) @(negedge clk);
            if (echo_width > 0) begin
                echo = 1'b1;
                repeat (echo_width) @(negedge clk);
                echo = 1'b0;
            end
        end
    end

    // Trigger width and ping spacing.
    initial begin
        int high_cycles;
        int since_rise;
        bit seen_rise;
        bit trig_d;
        high_cycles = 0;
        since_rise  = 0;
        seen_rise   = 1'b0;
        trig_d      = 1'b0;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge clk);
            since_rise++;
            if (trig && !trig_d) begin
                if (seen_rise) check_trig("ping period", PING_CYCLES, since_rise);
                seen_rise  = 1'b1;
                since_rise = 0;
            end
            if (trig) high_cycles++;
            if (!trig && trig_d) begin
                check_trig("trig width", TRIG_CYCLES, high_cycles);
                high_cycles = 0;
            end
            if (since_rise > PING_CYCLES) abort_run("The ranger stopped sending triggers.");
            trig_d = trig;
        end
    end

    initial begin
        longint timeout_ns;
        wait (tests_loaded);
        timeout_ns = longint'(num_tests) * 4 * PING_CYCLES * CLK_PERIOD + 1000;
        #(timeout_ns);
        abort_run("Timeout: the tests did not finish in the expected time.");
    end

    initial begin
        int left_high;
        int right_high;
        rst_n        = 1'b0;
        button       = 1'b0;
        sensors      = '0;
        enable_stop  = 1'b0;
        echo_width   = 0;
        error_count  = 0;
        tests_loaded = 1'b0;
        read_tests();
        num_tests = op_q.size();
        if (num_tests == 0) abort_run("The test file holds no tests.");
        tests_loaded = 1'b1;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_dir("reset left_dir", line_car_pkg::MOTOR_OFF, left_dir);
        check_dir("reset right_dir", line_car_pkg::MOTOR_OFF, right_dir);
        count_pwm(left_high, right_high);
        check_pwm("reset left_pwm", 0, left_high);
        check_pwm("reset right_pwm", 0, right_high);

        for (int i = 0; i < num_tests; i++) begin
            run_test(i);
        end

        if (error_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("RESULT: FAIL");
            $fatal(1, "Checks failed.");
        end
    end

endmodule

`default_nettype wire

// ==== line_car_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// Defaults assume a 100 MHz board clock.
module line_car_top #(
    parameter int DEBOUNCE_LEN = 16,
    parameter int TRIG_CYCLES  = 1000,     // 10 us trigger.
    parameter int PING_CYCLES  = 10000000, // 100 ms between pings.
    parameter int STOP_CYCLES  = 232000,   // Roughly 40 cm.
    parameter int PWM_PERIOD   = 1024,
    parameter int PWM_DUTY     = 720
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              button,
    input  logic                              echo,
    input  logic [line_car_pkg::SENSOR_W-1:0] sensors,
    input  logic                              enable_stop,
    output logic                              trig,
    output logic                              left_pwm,
    output logic                              right_pwm,
    output line_car_pkg::motor_dir_e          left_dir,
    output line_car_pkg::motor_dir_e          right_dir,
    output logic [line_car_pkg::SENSOR_W-1:0] lights
);

    logic                              start_pulse;
    logic                              obstacle;
    logic [line_car_pkg::SENSOR_W-1:0] line_pos;

    button_conditioner #(
        .DEBOUNCE_LEN(DEBOUNCE_LEN)
    ) i_button_conditioner (
        .clk        (clk),
        .rst_n      (rst_n),
        .button     (button),
        .start_pulse(start_pulse)
    );

    line_tracker i_line_tracker (
        .clk     (clk),
        .rst_n   (rst_n),
        .sensors (sensors),
        .line_pos(line_pos),
        .lights  (lights)
    );

    sonic_ranger #(
        .TRIG_CYCLES(TRIG_CYCLES),
        .PING_CYCLES(PING_CYCLES),
        .STOP_CYCLES(STOP_CYCLES)
    ) i_sonic_ranger (
        .clk     (clk),
        .rst_n   (rst_n),
        .echo    (echo),
        .trig    (trig),
        .obstacle(obstacle)
    );

    steer_ctrl i_steer_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_pulse(start_pulse),
        .line_pos   (line_pos),
        .obstacle   (obstacle),
        .enable_stop(enable_stop),
        .left_dir   (left_dir),
        .right_dir  (right_dir)
    );

    motor_pwm #(
        .PWM_PERIOD(PWM_PERIOD),
        .PWM_DUTY  (PWM_DUTY)
    ) i_motor_pwm (
        .clk      (clk),
        .rst_n    (rst_n),
        .left_dir (left_dir),
        .right_dir(right_dir),
        .left_pwm (left_pwm),
        .right_pwm(right_pwm)
    );

endmodule

`default_nettype wire

// ==== motor_pwm.sv ====
`timescale 1ns/1ps
`default_nettype none

module motor_pwm #(
    parameter int PWM_PERIOD = 1024,
    parameter int PWM_DUTY   = 720
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  line_car_pkg::motor_dir_e left_dir,
    input  line_car_pkg::motor_dir_e right_dir,
    output logic                     left_pwm,
    output logic                     right_pwm
);

    // One extra bit so a full duty still fits the compare.
    localparam int CNT_W = $clog2(PWM_PERIOD + 1);

    logic [CNT_W-1:0] pwm_cnt;
    logic             pwm_on;
    logic             cnt_wrap;

    assign cnt_wrap = (pwm_cnt == CNT_W'(PWM_PERIOD - 1));
    assign pwm_on   = (pwm_cnt < CNT_W'(PWM_DUTY));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pwm_cnt <= '0;
        end else begin
            pwm_cnt <= cnt_wrap ? '0 : pwm_cnt + 1'b1;
        end
    end

    // Registered so the enables to the driver never glitch.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            left_pwm  <= 1'b0;
            right_pwm <= 1'b0;
        end else begin
            left_pwm  <= pwm_on && (left_dir != line_car_pkg::MOTOR_OFF);
            right_pwm <= pwm_on && (right_dir != line_car_pkg::MOTOR_OFF);
        end
    end

endmodule

`default_nettype wire

// ==== steer_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module steer_ctrl (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              start_pulse,
    input  logic [line_car_pkg::SENSOR_W-1:0] line_pos,
    input  logic                              obstacle,
    input  logic                              enable_stop,
    output line_car_pkg::motor_dir_e          left_dir,
    output line_car_pkg::motor_dir_e          right_dir
);

    line_car_pkg::steer_state_e state;
    line_car_pkg::steer_state_e state_nxt;

    line_car_pkg::motor_dir_e tbl_left;
    line_car_pkg::motor_dir_e tbl_right;
    line_car_pkg::motor_dir_e cmd_left;
    line_car_pkg::motor_dir_e cmd_right;
    line_car_pkg::motor_dir_e run_left;
    line_car_pkg::motor_dir_e run_right;
    logic                     tbl_valid;
    logic                     stop_req;

    assign stop_req = obstacle & enable_stop;

    always_comb begin
        state_nxt = state;
        case (state)
            line_car_pkg::ST_IDLE:
                if (start_pulse) state_nxt = line_car_pkg::ST_RUN;
            line_car_pkg::ST_RUN:
                if (start_pulse) state_nxt = line_car_pkg::ST_IDLE;
                else if (stop_req) state_nxt = line_car_pkg::ST_BLOCKED;
            line_car_pkg::ST_BLOCKED:
                if (start_pulse) state_nxt = line_car_pkg::ST_IDLE;
                else if (!stop_req) state_nxt = line_car_pkg::ST_RUN;
            default:
                state_nxt = line_car_pkg::ST_IDLE;
        endcase
    end

    // Line position to wheel directions, left sensor is the MSB.
    always_comb begin
        tbl_valid = 1'b1;
        tbl_left  = line_car_pkg::MOTOR_FWD;
        tbl_right = line_car_pkg::MOTOR_FWD;
        case (line_pos)
            3'b010, 3'b111: begin
                tbl_left  = line_car_pkg::MOTOR_FWD;
                tbl_right = line_car_pkg::MOTOR_FWD;
            end
            3'b100: tbl_left = line_car_pkg::MOTOR_REV;  // Sharp left.
            3'b110: tbl_left = line_car_pkg::MOTOR_OFF;  // Soft left.
            3'b001: tbl_right = line_car_pkg::MOTOR_REV; // Sharp right.
            3'b011: tbl_right = line_car_pkg::MOTOR_OFF; // Soft right.
            default: tbl_valid = 1'b0;                   // Lost line or 101.
        endcase
    end

    assign run_left  = tbl_valid ? tbl_left : cmd_left;
    assign run_right = tbl_valid ? tbl_right : cmd_right;

    // The remembered command falls back to straight ahead outside ST_RUN.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= line_car_pkg::ST_IDLE;
            cmd_left  <= line_car_pkg::MOTOR_FWD;
            cmd_right <= line_car_pkg::MOTOR_FWD;
            left_dir  <= line_car_pkg::MOTOR_OFF;
            right_dir <= line_car_pkg::MOTOR_OFF;
        end else begin
            state <= state_nxt;
            if (state_nxt == line_car_pkg::ST_RUN) begin
                cmd_left  <= run_left;
                cmd_right <= run_right;
                left_dir  <= run_left;
                right_dir <= run_right;
            end else begin
                cmd_left  <= line_car_pkg::MOTOR_FWD;
                cmd_right <= line_car_pkg::MOTOR_FWD;
                left_dir  <= line_car_pkg::MOTOR_OFF;
                right_dir <= line_car_pkg::MOTOR_OFF;
            end
        end
    end

endmodule

`default_nettype wire

// ==== sonic_ranger.sv ====
`timescale 1ns/1ps
`default_nettype none

module sonic_ranger #(
    parameter int TRIG_CYCLES = 1000,
    parameter int PING_CYCLES = 10000000,
    parameter int STOP_CYCLES = 232000
) (
    input  logic clk,
    input  logic rst_n,
    input  logic echo,
    output logic trig,
    output logic obstacle
);

    localparam int PERIOD_W = $clog2(PING_CYCLES);
    localparam int WIDTH_W  = $clog2(STOP_CYCLES + 1);

    line_car_pkg::ranger_state_e state;
    line_car_pkg::ranger_state_e state_nxt;

    logic [PERIOD_W-1:0] period_cnt;
    logic [WIDTH_W-1:0]  width_cnt;
    logic                echo_meta;
    logic                echo_sync;
    logic                echo_d;
    logic                echo_rise;
    logic                echo_fall;
    logic                period_end;
    logic                trig_end;

    assign echo_rise  = echo_sync & ~echo_d;
    assign echo_fall  = ~echo_sync & echo_d;
    assign period_end = (period_cnt == PERIOD_W'(PING_CYCLES - 1));
    assign trig_end   = (period_cnt == PERIOD_W'(TRIG_CYCLES - 1));
    assign trig       = (state == line_car_pkg::RG_TRIG);

    always_comb begin
        state_nxt = state;
        if (period_end) begin
            state_nxt = line_car_pkg::RG_TRIG; // Every period restarts with a ping.
        end else begin
            case (state)
                line_car_pkg::RG_TRIG:
                    if (trig_end) state_nxt = line_car_pkg::RG_WAIT_ECHO;
                line_car_pkg::RG_WAIT_ECHO:
                    if (echo_rise) state_nxt = line_car_pkg::RG_MEASURE;
                line_car_pkg::RG_MEASURE:
                    if (echo_fall) state_nxt = line_car_pkg::RG_PAUSE;
                default:
                    state_nxt = state;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            echo_meta <= 1'b0;
            echo_sync <= 1'b0;
            echo_d    <= 1'b0;
        end else begin
            echo_meta <= echo;
            echo_sync <= echo_meta;
            echo_d    <= echo_sync;
        end
    end

    // Reset parks at the end of a period so the first ping follows at once.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= line_car_pkg::RG_PAUSE;
            period_cnt <= PERIOD_W'(PING_CYCLES - 1);
            width_cnt  <= '0;
            obstacle   <= 1'b0;
        end else begin
            state      <= state_nxt;
            period_cnt <= period_end ? '0 : period_cnt + 1'b1;

            if (state == line_car_pkg::RG_WAIT_ECHO && echo_rise) begin
                width_cnt <= WIDTH_W'(1);
            end else if (state == line_car_pkg::RG_MEASURE && echo_sync &&
                         width_cnt != WIDTH_W'(STOP_CYCLES)) begin
                width_cnt <= width_cnt + 1'b1; // Saturates at the stop threshold.
            end

            if (state == line_car_pkg::RG_MEASURE && echo_fall) begin
                obstacle <= (width_cnt < WIDTH_W'(STOP_CYCLES));
            end else if (period_end && state != line_car_pkg::RG_PAUSE) begin
                obstacle <= 1'b0; // No echo, or one too long to matter.
            end
        end
    end

endmodule

`default_nettype wire

// ==== line_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_tracker (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [line_car_pkg::SENSOR_W-1:0] sensors,
    output logic [line_car_pkg::SENSOR_W-1:0] line_pos,
    output logic [line_car_pkg::SENSOR_W-1:0] lights
);

    logic [line_car_pkg::SENSOR_W-1:0] sensors_meta;
    logic [line_car_pkg::SENSOR_W-1:0] sensors_sync;

    // The sensor comparators are not related to clk.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sensors_meta <= '0;
            sensors_sync <= '0;
        end else begin
            sensors_meta <= sensors;
            sensors_sync <= sensors_meta;
        end
    end

    // Steering and lights see the same synchronized sample.
    assign line_pos = sensors_sync;
    assign lights   = sensors_sync;

endmodule

`default_nettype wire

// ==== button_conditioner.sv ====
`timescale 1ns/1ps
`default_nettype none

module button_conditioner #(
    parameter int DEBOUNCE_LEN = 16
) (
    input  logic clk,
    input  logic rst_n,
    input  logic button,
    output logic start_pulse
);

    logic [DEBOUNCE_LEN-1:0] samples;
    logic                    pressed;
    logic                    pressed_q;

    // Pressed only once every sample in the window is high.
    assign pressed = &samples;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            samples     <= '0;
            pressed_q   <= 1'b0;
            start_pulse <= 1'b0;
        end else begin
            samples     <= {samples[DEBOUNCE_LEN-2:0], button};
            pressed_q   <= pressed;
            start_pulse <= pressed & ~pressed_q; // Rising edge only.
        end
    end

endmodule

`default_nettype wire

// ==== line_car_pkg.sv ====
`default_nettype none

package line_car_pkg;

    // Number of reflectance sensors, left is the MSB of every sensor vector.
    localparam int SENSOR_W = 3;

    // Motor direction, coded as on the driver board pins.
    typedef enum logic [1:0] {
        MOTOR_OFF = 2'b00,
        MOTOR_REV = 2'b01,
        MOTOR_FWD = 2'b10
    } motor_dir_e;

    // Steering controller state.
    typedef enum logic [1:0] {
        ST_IDLE    = 2'b00, // Car parked, motors off.
        ST_RUN     = 2'b01, // Following the line.
        ST_BLOCKED = 2'b10  // Obstacle ahead, motors off until it clears.
    } steer_state_e;

    // Ultrasonic ranger phase within one ping period.
    typedef enum logic [1:0] {
        RG_TRIG      = 2'b00, // Trigger pulse on the trig pin.
        RG_WAIT_ECHO = 2'b01, // Waiting for the echo to rise.
        RG_MEASURE   = 2'b10, // Counting echo high time.
        RG_PAUSE     = 2'b11  // Idle until the period ends.
    } ranger_state_e;

endpackage

`default_nettype wire
